// ==== cpuPkg.sv ====
package cpuPkg;

  // --------------------------------------------------
  // Basic data types
  // --------------------------------------------------
  typedef logic [7:0] byteT;
  typedef logic [2:0] regAddrT;

  // ALU operations, first eight follow the ooo field of 10 ooo sss
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_ADC  = 4'd1,
    OP_SUB  = 4'd2,
    OP_SBC  = 4'd3,
    OP_AND  = 4'd4,
    OP_XOR  = 4'd5,
    OP_OR   = 4'd6,
    OP_CP   = 4'd7,
    OP_INC  = 4'd8,
    OP_DEC  = 4'd9,
    OP_LOAD = 4'd10,
    OP_CPL  = 4'd11,
    OP_SCF  = 4'd12,
    OP_CCF  = 4'd13
  } aluOpT;

  // --------------------------------------------------
  // Register codes
  // --------------------------------------------------
  localparam regAddrT REG_A = 3'd7;  // Accumulator
  localparam regAddrT REG_M = 3'd6;  // (HL) slot, no memory here

  // --------------------------------------------------
  // Flag bit positions in F
  // --------------------------------------------------
  localparam int FLAG_S  = 7;
  localparam int FLAG_Z  = 6;
  localparam int FLAG_H  = 4;
  localparam int FLAG_PV = 2;
  localparam int FLAG_N  = 1;
  localparam int FLAG_C  = 0;

  // Reset values
  localparam byteT ACC_RESET   = 8'hFF;
  // All ones except the two unused bits 5 and 3
  localparam byteT FLAGS_RESET = 8'hD7;

endpackage

// ==== decodedOpIf.sv ====
interface decodedOpIf;

  logic                  valid;     // One cycle per legal instruction
  cpuPkg::aluOpT         aluOp;
  cpuPkg::regAddrT       dstReg;
  cpuPkg::regAddrT       srcReg;
  logic                  useImm;    // Second operand from imm
  cpuPkg::byteT          imm;
  logic                  writeReg;  // Result goes to dstReg

  modport decode (
    output valid,
    output aluOp,
    output dstReg,
    output srcReg,
    output useImm,
    output imm,
    output writeReg
  );

  modport execute (
    input valid,
    input aluOp,
    input dstReg,
    input srcReg,
    input useImm,
    input imm,
    input writeReg
  );

endinterface

// ==== writebackIf.sv ====
interface writebackIf;

  logic            valid;     // One cycle per executed instruction
  logic            writeReg;
  cpuPkg::regAddrT dstReg;
  cpuPkg::byteT    data;
  cpuPkg::byteT    flags;     // Complete new F value

  // Execute side
  modport execute (
    output valid,
    output writeReg,
    output dstReg,
    output data,
    output flags
  );

  // Register file side
  modport writeback (
    input valid,
    input writeReg,
    input dstReg,
    input data,
    input flags
  );

endinterface

// ==== instDecode.sv ====
module instDecode (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         instValid,
  input  cpuPkg::byteT opcode,
  input  cpuPkg::byteT operand,
  decodedOpIf.decode   op
);

  logic [1:0]      opGroup;
  cpuPkg::regAddrT dstField;
  cpuPkg::regAddrT srcField;

  logic            legal;
  cpuPkg::aluOpT   nextOp;
  cpuPkg::regAddrT nextDst;
  cpuPkg::regAddrT nextSrc;
  logic            nextUseImm;
  logic            nextWrite;

  // Opcode fields, gg ddd sss
  assign opGroup  = opcode[7:6];
  assign dstField = opcode[5:3];
  assign srcField = opcode[2:0];

  // --------------------------------------------------
  // Recognise the kept forms
  // --------------------------------------------------
  always_comb
  begin
    legal      = 1'b0;
    nextOp     = cpuPkg::OP_LOAD;
    nextDst    = dstField;
    nextSrc    = srcField;
    nextUseImm = 1'b0;
    nextWrite  = 1'b1;

    case (opGroup)
      2'b00:
      begin
        case (srcField)
          3'b100, 3'b101:  // INC r / DEC r
          begin
            legal  = (dstField != cpuPkg::REG_M);
            nextOp = srcField[0] ? cpuPkg::OP_DEC : cpuPkg::OP_INC;
          end
          3'b110:          // LD r,n
          begin
            legal      = (dstField != cpuPkg::REG_M);
            nextUseImm = 1'b1;
          end
          3'b111:
          begin
            // Only CPL, SCF and CCF survive from this column
            nextDst = cpuPkg::REG_A;
            case (dstField)
              3'b101:
              begin
                legal  = 1'b1;
                nextOp = cpuPkg::OP_CPL;
              end
              3'b110:
              begin
                legal     = 1'b1;
                nextOp    = cpuPkg::OP_SCF;
                nextWrite = 1'b0;
              end
              3'b111:
              begin
                legal     = 1'b1;
                nextOp    = cpuPkg::OP_CCF;
                nextWrite = 1'b0;
              end
              default: legal = 1'b0;
            endcase
          end
          default: legal = 1'b0;
        endcase
      end

      // LD r,r', 76 (HALT) falls out here too
      2'b01:
        legal = (dstField != cpuPkg::REG_M) && (srcField != cpuPkg::REG_M);

      // Accumulator ops, register form in 10 and immediate form in 11
      default:
      begin
        legal      = opGroup[0] ? (srcField == cpuPkg::REG_M) : (srcField != cpuPkg::REG_M);
        nextUseImm = opGroup[0];
        nextOp     = cpuPkg::aluOpT'({1'b0, dstField});
        nextDst    = cpuPkg::REG_A;
        nextWrite  = (nextOp != cpuPkg::OP_CP);  // CP only touches F
      end
    endcase
  end

  // --------------------------------------------------
  // Decode register
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      op.valid <= 1'b0;
    else
      op.valid <= instValid && legal;
  end

  always_ff @(posedge clk)
  begin
    op.aluOp    <= nextOp;
    op.dstReg   <= nextDst;
    op.srcReg   <= nextSrc;
    op.useImm   <= nextUseImm;
    op.imm      <= operand;
    op.writeReg <= nextWrite;
  end

endmodule

// ==== aluExecute.sv ====
module aluExecute (
  input  logic            clk,
  input  logic            reset_n,
  decodedOpIf.execute     op,
  output cpuPkg::regAddrT rdAddr,
  input  cpuPkg::byteT    rdData,
  input  cpuPkg::byteT    accData,
  input  cpuPkg::byteT    flagData,
  writebackIf.execute     wb
);

  logic         isIncDec;
  logic         isSub;
  logic         carryIn;
  cpuPkg::byteT opA;
  cpuPkg::byteT opB;
  logic [8:0]   sumWide;    // Bit 8 is carry or borrow
  logic [4:0]   halfWide;   // Bit 4 is half carry or borrow
  logic         overflow;
  cpuPkg::byteT result;
  cpuPkg::byteT newFlags;

  assign isIncDec = (op.aluOp == cpuPkg::OP_INC) || (op.aluOp == cpuPkg::OP_DEC);

  // INC and DEC work on their own destination
  assign rdAddr = isIncDec ? op.dstReg : op.srcReg;

  // --------------------------------------------------
  // Operand select and adder
  // --------------------------------------------------
  always_comb
  begin
    opA     = accData;
    opB     = op.useImm ? op.imm : rdData;
    carryIn = 1'b0;
    isSub   = 1'b0;

    case (op.aluOp)
      cpuPkg::OP_ADC: carryIn = flagData[cpuPkg::FLAG_C];
      cpuPkg::OP_SUB,
      cpuPkg::OP_CP:  isSub = 1'b1;
      cpuPkg::OP_SBC:
      begin
        isSub   = 1'b1;
        carryIn = flagData[cpuPkg::FLAG_C];
      end
      cpuPkg::OP_INC:
      begin
        opA = rdData;
        opB = 8'h01;
      end
      cpuPkg::OP_DEC:
      begin
        opA   = rdData;
        opB   = 8'h01;
        isSub = 1'b1;
      end
      default: ;
    endcase

    if (isSub)
    begin
      sumWide  = {1'b0, opA} - {1'b0, opB} - {8'h00, carryIn};
      halfWide = {1'b0, opA[3:0]} - {1'b0, opB[3:0]} - {4'h0, carryIn};
      overflow = (opA[7] != opB[7]) && (sumWide[7] != opA[7]);
    end
    else
    begin
      sumWide  = {1'b0, opA} + {1'b0, opB} + {8'h00, carryIn};
      halfWide = {1'b0, opA[3:0]} + {1'b0, opB[3:0]} + {4'h0, carryIn};
      overflow = (opA[7] == opB[7]) && (sumWide[7] != opA[7]);
    end
  end

  // --------------------------------------------------
  // Result and flag byte
  // --------------------------------------------------
  always_comb
  begin
    result   = sumWide[7:0];
    newFlags = flagData;  // Unchanged unless the op says otherwise

    case (op.aluOp)
      cpuPkg::OP_ADD, cpuPkg::OP_ADC, cpuPkg::OP_SUB, cpuPkg::OP_SBC,
      cpuPkg::OP_CP, cpuPkg::OP_INC, cpuPkg::OP_DEC:
      begin
        newFlags[cpuPkg::FLAG_S]  = sumWide[7];
        newFlags[cpuPkg::FLAG_Z]  = (sumWide[7:0] == 8'h00);
        newFlags[cpuPkg::FLAG_H]  = halfWide[4];
        newFlags[cpuPkg::FLAG_PV] = overflow;
        newFlags[cpuPkg::FLAG_N]  = isSub;
        if (!isIncDec)
          newFlags[cpuPkg::FLAG_C] = sumWide[8];  // INC/DEC keep C
      end
      cpuPkg::OP_AND: result = opA & opB;
      cpuPkg::OP_XOR: result = opA ^ opB;
      cpuPkg::OP_OR:  result = opA | opB;
      cpuPkg::OP_LOAD: result = opB;
      cpuPkg::OP_CPL:
      begin
        result                   = ~accData;
        newFlags[cpuPkg::FLAG_H] = 1'b1;
        newFlags[cpuPkg::FLAG_N] = 1'b1;
      end
      cpuPkg::OP_SCF:
      begin
        result                   = accData;
        newFlags[cpuPkg::FLAG_C] = 1'b1;
        newFlags[cpuPkg::FLAG_H] = 1'b0;
        newFlags[cpuPkg::FLAG_N] = 1'b0;
      end
      cpuPkg::OP_CCF:
      begin
        result                   = accData;
        newFlags[cpuPkg::FLAG_H] = flagData[cpuPkg::FLAG_C];
        newFlags[cpuPkg::FLAG_C] = ~flagData[cpuPkg::FLAG_C];
        newFlags[cpuPkg::FLAG_N] = 1'b0;
      end
      default: ;
    endcase

    // Shared flags of the three logic ops
    if (op.aluOp inside {cpuPkg::OP_AND, cpuPkg::OP_XOR, cpuPkg::OP_OR})
    begin
      newFlags[cpuPkg::FLAG_S]  = result[7];
      newFlags[cpuPkg::FLAG_Z]  = (result == 8'h00);
      newFlags[cpuPkg::FLAG_H]  = (op.aluOp == cpuPkg::OP_AND);
      newFlags[cpuPkg::FLAG_PV] = ~^result;  // Even parity
      newFlags[cpuPkg::FLAG_N]  = 1'b0;
      newFlags[cpuPkg::FLAG_C]  = 1'b0;
    end
  end

  // --------------------------------------------------
  // Execute register
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      wb.valid <= 1'b0;
    else
      wb.valid <= op.valid;
  end

  always_ff @(posedge clk)
  begin
    wb.writeReg <= op.writeReg;
    wb.dstReg   <= op.dstReg;
    wb.data     <= result;
    wb.flags    <= newFlags;
  end

endmodule

// ==== regWriteback.sv ====
module regWriteback (
  input  logic            clk,
  input  logic            reset_n,
  writebackIf.writeback   wb,
  input  cpuPkg::regAddrT rdAddr,
  output cpuPkg::byteT    rdData,
  output cpuPkg::byteT    accData,
  output cpuPkg::byteT    flagData,
  output logic            retire,
  output logic            regWrite,
  output cpuPkg::regAddrT wbReg,
  output cpuPkg::byteT    wbData,
  output cpuPkg::byteT    flags
);

  cpuPkg::byteT regFile [8];  // Slot 6 is never written
  cpuPkg::byteT flagReg;
  logic         pendingWrite;

  // --------------------------------------------------
  // Register file and F
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < 8; i++)
        regFile[i] <= (cpuPkg::regAddrT'(i) == cpuPkg::REG_A) ? cpuPkg::ACC_RESET : 8'h00;
      flagReg <= cpuPkg::FLAGS_RESET;
    end
    else if (wb.valid)
    begin
      flagReg <= wb.flags;  // Every op delivers a full F
      if (wb.writeReg)
        regFile[wb.dstReg] <= wb.data;
    end
  end

  // Reads see the value about to be written this edge
  assign pendingWrite = wb.valid && wb.writeReg;

  assign rdData   = (pendingWrite && (wb.dstReg == rdAddr)) ? wb.data : regFile[rdAddr];
  assign accData  = (pendingWrite && (wb.dstReg == cpuPkg::REG_A)) ? wb.data
                                                                   : regFile[cpuPkg::REG_A];
  assign flagData = wb.valid ? wb.flags : flagReg;

  // --------------------------------------------------
  // Retirement outputs
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      retire   <= 1'b0;
      regWrite <= 1'b0;
    end
    else
    begin
      retire   <= wb.valid;
      regWrite <= pendingWrite;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wb.valid)
    begin
      wbReg  <= wb.dstReg;
      wbData <= wb.data;
    end
  end

  assign flags = flagReg;  // Already holds the retiring F

endmodule

// ==== byteCore.sv ====
module byteCore (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            instValid,
  input  cpuPkg::byteT    opcode,
  input  cpuPkg::byteT    operand,
  output logic            retire,
  output logic            regWrite,
  output cpuPkg::regAddrT wbReg,
  output cpuPkg::byteT    wbData,
  output cpuPkg::byteT    flags
);

  decodedOpIf decodedOp ();
  writebackIf wbBus ();

  // Operand read path, execute to register file
  cpuPkg::regAddrT rdAddr;
  cpuPkg::byteT    rdData;
  cpuPkg::byteT    accData;
  cpuPkg::byteT    flagData;

  // --------------------------------------------------
  // Decode, execute, writeback
  // --------------------------------------------------
  instDecode uDecode (
    .clk       (clk),
    .reset_n   (reset_n),
    .instValid (instValid),
    .opcode    (opcode),
    .operand   (operand),
    .op        (decodedOp.decode)
  );

  aluExecute uExecute (
    .clk      (clk),
    .reset_n  (reset_n),
    .op       (decodedOp.execute),
    .rdAddr   (rdAddr),
    .rdData   (rdData),
    .accData  (accData),
    .flagData (flagData),
    .wb       (wbBus.execute)
  );

  regWriteback uWriteback (
    .clk      (clk),
    .reset_n  (reset_n),
    .wb       (wbBus.writeback),
    .rdAddr   (rdAddr),
    .rdData   (rdData),
    .accData  (accData),
    .flagData (flagData),
    .retire   (retire),
    .regWrite (regWrite),
    .wbReg    (wbReg),
    .wbData   (wbData),
    .flags    (flags)
  );

endmodule

// ==== byteCore_assertions.sv ====
module byteCore_assertions (
  input logic            clk,
  input logic            reset_n,
  input logic            retire,
  input logic            regWrite,
  input cpuPkg::regAddrT wbReg,
  input cpuPkg::byteT    flags
);

  // --------------------------------------------------
  // Retirement port rules
  // --------------------------------------------------
  property writeNeedsRetire;
    @(posedge clk) disable iff (!reset_n) regWrite |-> retire;
  endproperty

  property noWriteToSlotSix;
    @(posedge clk) disable iff (!reset_n) regWrite |-> (wbReg != 3'd6);  // (HL) slot
  endproperty

  property unusedFlagBitsZero;
    @(posedge clk) disable iff (!reset_n) !flags[5] && !flags[3];
  endproperty

  assert property (writeNeedsRetire)
    else $error("regWrite high without retire");
  assert property (noWriteToSlotSix)
    else $error("Register write to code 6");
  assert property (unusedFlagBitsZero)
    else $error("Flag bit 5 or 3 is set");

endmodule

bind byteCore byteCore_assertions coreChecks (
  .clk      (clk),
  .reset_n  (reset_n),
  .retire   (retire),
  .regWrite (regWrite),
  .wbReg    (wbReg),
  .flags    (flags)
);

// ==== byteCore_tb.sv ====
module byteCore_tb;

  localparam int CLK_PERIOD      = 40;
  localparam int DRIVE_DELAY     = 2;
  localparam int RESET_CYCLES    = 5;
  localparam int NUM_RANDOM      = 200;
  localparam int CYCLES_PER_INST = 50;

  typedef struct packed {
    logic [31:0] dueEdge;   // Edge after which retire must be high
    logic        regWrite;
    logic [2:0]  wbReg;
    logic [7:0]  wbData;
    logic [7:0]  flags;
  } expectT;

  typedef struct packed {
    logic [3:0] gap;        // Idle cycles before the strobe
    logic [7:0] opc;
    logic [7:0] imm;
    logic       retires;
    logic       regWrite;
    logic [2:0] wbReg;
    logic [7:0] wbData;
    logic [7:0] flags;
  } tableEntryT;

  logic            clk;
  logic            reset_n;
  logic            instValid;
  cpuPkg::byteT    opcode;
  cpuPkg::byteT    operand;
  logic            retire;
  logic            regWrite;
  cpuPkg::regAddrT wbReg;
  cpuPkg::byteT    wbData;
  cpuPkg::byteT    flags;

  tableEntryT  stimTable [$];
  expectT      expQ [$];
  logic [7:0]  modelRegs [8];
  logic [7:0]  modelF;
  logic [31:0] rngState;
  logic [31:0] edgeCount;
  logic        tableBuilt;

  byteCore dut (
    .clk       (clk),
    .reset_n   (reset_n),
    .instValid (instValid),
    .opcode    (opcode),
    .operand   (operand),
    .retire    (retire),
    .regWrite  (regWrite),
    .wbReg     (wbReg),
    .wbData    (wbData),
    .flags     (flags)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
    edgeCount <= edgeCount + 1;

  // --------------------------------------------------
  // Reporting
  // --------------------------------------------------
  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected)
      failRun($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected));
  endtask

  // --------------------------------------------------
  // Reference model of the registers and F
  // --------------------------------------------------
  function automatic logic [7:0] packFlags(input logic s, input logic z, input logic h,
                                           input logic pv, input logic n, input logic c);
    return {s, z, 1'b0, h, 1'b0, pv, n, c};  // S7 Z6 H4 PV2 N1 C0
  endfunction

  function automatic logic evenParity(input logic [7:0] v);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++)
      ones += v[i];
    return (ones % 2) == 0;
  endfunction

  function automatic int toSigned(input logic [7:0] v);
    return v[7] ? int'(v) - 256 : int'(v);
  endfunction

  task automatic calcArith(input logic [7:0] a, input logic [7:0] b, input logic cin,
                           input logic sub, output logic [7:0] res, output logic [7:0] fl);
    int   full;
    int   half;
    int   sres;
    logic carry;
    logic halfCarry;
    if (sub)
    begin
      full      = int'(a) - int'(b) - int'(cin);
      half      = int'(a[3:0]) - int'(b[3:0]) - int'(cin);
      sres      = toSigned(a) - toSigned(b) - int'(cin);
      carry     = (full < 0);     // Borrow
      halfCarry = (half < 0);
    end
    else
    begin
      full      = int'(a) + int'(b) + int'(cin);
      half      = int'(a[3:0]) + int'(b[3:0]) + int'(cin);
      sres      = toSigned(a) + toSigned(b) + int'(cin);
      carry     = (full > 255);
      halfCarry = (half > 15);
    end
    res = full[7:0];
    fl  = packFlags(res[7], res == 8'h00, halfCarry, (sres < -128) || (sres > 127), sub, carry);
  endtask

  // The eight accumulator operations selected by the ooo field
  task automatic calcAccOp(input logic [2:0] sel, input logic [7:0] b,
                           output logic [7:0] res, output logic [7:0] fl, output logic wr);
    logic [7:0] a;
    logic       c;
    a  = modelRegs[7];
    c  = modelF[0];
    wr = (sel != 3'd7);  // CP only sets F
    case (sel)
      3'd0: calcArith(a, b, 1'b0, 1'b0, res, fl);
      3'd1: calcArith(a, b, c, 1'b0, res, fl);
      3'd2: calcArith(a, b, 1'b0, 1'b1, res, fl);
      3'd3: calcArith(a, b, c, 1'b1, res, fl);
      3'd7: calcArith(a, b, 1'b0, 1'b1, res, fl);
      default:
      begin
        case (sel)
          3'd4: res = a & b;
          3'd5: res = a ^ b;
          default: res = a | b;
        endcase
        fl = packFlags(res[7], res == 8'h00, sel == 3'd4, evenParity(res), 1'b0, 1'b0);
      end
    endcase
  endtask

  task automatic modelStep(input logic [7:0] opc, input logic [7:0] imm,
                           output logic legal, output expectT e);
    logic [2:0] d;
    logic [2:0] s;
    logic [2:0] dst;
    logic [7:0] res;
    logic [7:0] fl;
    logic       wr;
    d     = opc[5:3];
    s     = opc[2:0];
    dst   = d;
    res   = 8'h00;
    fl    = modelF;
    wr    = 1'b0;
    legal = 1'b0;
    case (opc[7:6])
      2'b00:
      begin
        if (s == 3'd6 && d != 3'd6)  // LD r,n
        begin
          legal = 1'b1;
          wr    = 1'b1;
          res   = imm;
        end
        else if ((s == 3'd4 || s == 3'd5) && d != 3'd6)
        begin
          legal = 1'b1;
          wr    = 1'b1;
          calcArith(modelRegs[d], 8'h01, 1'b0, s[0], res, fl);
          fl[0] = modelF[0];  // INC/DEC keep C
        end
        else if (opc == 8'h2F || opc == 8'h37 || opc == 8'h3F)
        begin
          legal = 1'b1;
          dst   = 3'd7;
          res   = modelRegs[7];
          if (opc == 8'h2F)
          begin
            wr  = 1'b1;
            res = ~modelRegs[7];
            fl  = modelF | 8'h12;
          end
          else if (opc == 8'h37)
            fl = (modelF & ~8'h12) | 8'h01;
          else
            fl = {modelF[7:5], modelF[0], modelF[3:2], 1'b0, ~modelF[0]};
        end
      end
      2'b01:
      begin
        legal = (d != 3'd6) && (s != 3'd6);
        wr    = 1'b1;
        res   = modelRegs[s];
      end
      2'b10:
      begin
        legal = (s != 3'd6);
        dst   = 3'd7;
        calcAccOp(d, modelRegs[s], res, fl, wr);
      end
      default:
      begin
        legal = (s == 3'd6);
        dst   = 3'd7;
        calcAccOp(d, imm, res, fl, wr);
      end
    endcase
    if (legal)
    begin
      if (wr)
        modelRegs[dst] = res;
      modelF = fl;
    end
    e = '{dueEdge: 32'd0, regWrite: wr, wbReg: dst, wbData: res, flags: fl};
  endtask

  task automatic resetModel();
    for (int i = 0; i < 8; i++)
      modelRegs[i] = 8'h00;
    modelRegs[7] = 8'hFF;
    modelF       = 8'hFF & ~8'h28;  // Bits 5 and 3 read as 0
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [2:0] pickReg(input logic [31:0] r);
    logic [2:0] v;
    v = 3'(r % 7);
    return (v == 3'd6) ? 3'd7 : v;  // Skip the (HL) slot
  endfunction

  task automatic makeRandomInst(output logic [7:0] opc, output logic [7:0] imm);
    logic [31:0] r;
    logic [2:0]  d;
    logic [2:0]  s;
    rngState = xorshift32(rngState);
    r        = rngState;
    d        = pickReg(r >> 4);
    s        = pickReg(r >> 9);
    imm      = r[23:16];
    case (r % 6)
      0: opc = {2'b00, d, 3'b110};
      1: opc = {2'b01, d, s};
      2: opc = {2'b00, d, 2'b10, r[14]};   // INC or DEC
      3: opc = {2'b10, r[26:24], s};
      4: opc = {2'b11, r[26:24], 3'b110};
      default:
      begin
        case (r[29:28])
          2'd0, 2'd1: opc = 8'h2F;
          2'd2: opc = 8'h37;
          default: opc = 8'h3F;
        endcase
      end
    endcase
  endtask

  task automatic issueInst(input logic [7:0] opc, input logic [7:0] imm,
                           output logic [31:0] due);
    @(posedge clk);
    #DRIVE_DELAY;
    instValid = 1'b1;
    opcode    = opc;
    operand   = imm;
    due       = edgeCount + 3;  // Sampling edge counted as the first
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #DRIVE_DELAY;
    instValid = 1'b0;
  endtask

  task automatic addEntry(input logic [3:0] gap, input logic [7:0] opc, input logic [7:0] imm,
                          input logic retires, input logic regWr, input logic [2:0] dstReg,
                          input logic [7:0] data, input logic [7:0] fl);
    stimTable.push_back({gap, opc, imm, retires, regWr, dstReg, data, fl});
  endtask

  task automatic buildTable();
    // gap, opcode, operand, retires, regWrite, wbReg, wbData, flags
    addEntry(3, 8'h3F, 8'h00, 1, 0, 3'd7, 8'hFF, 8'hD4);  // CCF from reset F
    addEntry(0, 8'h06, 8'h12, 1, 1, 3'd0, 8'h12, 8'hD4);  // LD B,n
    addEntry(0, 8'h0E, 8'h34, 1, 1, 3'd1, 8'h34, 8'hD4);
    addEntry(0, 8'h16, 8'h56, 1, 1, 3'd2, 8'h56, 8'hD4);
    addEntry(0, 8'h1E, 8'h78, 1, 1, 3'd3, 8'h78, 8'hD4);
    addEntry(2, 8'h26, 8'h9A, 1, 1, 3'd4, 8'h9A, 8'hD4);
    addEntry(0, 8'h2E, 8'hBC, 1, 1, 3'd5, 8'hBC, 8'hD4);
    addEntry(0, 8'h3E, 8'h0F, 1, 1, 3'd7, 8'h0F, 8'hD4);  // LD A,n
    addEntry(0, 8'h47, 8'h00, 1, 1, 3'd0, 8'h0F, 8'hD4);  // LD B,A
    addEntry(0, 8'h65, 8'h00, 1, 1, 3'd4, 8'hBC, 8'hD4);  // LD H,L
    addEntry(0, 8'h5A, 8'h00, 1, 1, 3'd3, 8'h56, 8'hD4);  // LD E,D
    addEntry(1, 8'hC6, 8'h01, 1, 1, 3'd7, 8'h10, 8'h10);  // Half carry
    addEntry(0, 8'hC6, 8'h70, 1, 1, 3'd7, 8'h80, 8'h84);  // Overflow
    addEntry(0, 8'hC6, 8'h80, 1, 1, 3'd7, 8'h00, 8'h45);  // Carry and zero
    addEntry(0, 8'hCE, 8'hFF, 1, 1, 3'd7, 8'h00, 8'h51);  // ADC n
    addEntry(0, 8'h91, 8'h00, 1, 1, 3'd7, 8'hCC, 8'h93);  // SUB C
    addEntry(0, 8'hDE, 8'h0B, 1, 1, 3'd7, 8'hC0, 8'h82);  // SBC n
    addEntry(0, 8'hD6, 8'h41, 1, 1, 3'd7, 8'h7F, 8'h16);  // SUB n with overflow
    addEntry(0, 8'hB8, 8'h00, 1, 0, 3'd7, 8'h70, 8'h02);  // CP B
    addEntry(0, 8'hFE, 8'h7F, 1, 0, 3'd7, 8'h00, 8'h42);  // CP n
    addEntry(0, 8'h47, 8'h00, 1, 1, 3'd0, 8'h7F, 8'h42);  // A survives CP
    addEntry(1, 8'hE6, 8'hF0, 1, 1, 3'd7, 8'h70, 8'h10);  // AND n
    addEntry(0, 8'hB3, 8'h00, 1, 1, 3'd7, 8'h76, 8'h00);  // OR E
    addEntry(0, 8'hAF, 8'h00, 1, 1, 3'd7, 8'h00, 8'h44);  // XOR A
    addEntry(0, 8'h37, 8'h00, 1, 0, 3'd7, 8'h00, 8'h45);  // SCF
    addEntry(0, 8'h3D, 8'h00, 1, 1, 3'd7, 8'hFF, 8'h93);  // DEC A keeps C
    addEntry(0, 8'h3C, 8'h00, 1, 1, 3'd7, 8'h00, 8'h51);  // Chained INC A
    addEntry(0, 8'h3C, 8'h00, 1, 1, 3'd7, 8'h01, 8'h01);
    addEntry(0, 8'h2F, 8'h00, 1, 1, 3'd7, 8'hFE, 8'h13);  // CPL
    addEntry(0, 8'h2C, 8'h00, 1, 1, 3'd5, 8'hBD, 8'h81);  // INC L
    addEntry(0, 8'h25, 8'h00, 1, 1, 3'd4, 8'hBB, 8'h83);  // DEC H
    addEntry(0, 8'h04, 8'h00, 1, 1, 3'd0, 8'h80, 8'h95);  // INC B with overflow
    addEntry(1, 8'h76, 8'h00, 0, 0, 3'd0, 8'h00, 8'h00);  // Illegal
    addEntry(0, 8'h34, 8'h00, 0, 0, 3'd0, 8'h00, 8'h00);  // Illegal
    addEntry(0, 8'h57, 8'h00, 1, 1, 3'd2, 8'hFE, 8'h95);  // LD D,A
    addEntry(0, 8'h80, 8'h00, 1, 1, 3'd7, 8'h7E, 8'h05);  // ADD A,B
    addEntry(0, 8'h8C, 8'h00, 1, 1, 3'd7, 8'h3A, 8'h11);  // ADC A,H
    addEntry(0, 8'h9B, 8'h00, 1, 1, 3'd7, 8'hE3, 8'h83);  // SBC A,E
    addEntry(0, 8'h3F, 8'h00, 1, 0, 3'd7, 8'hE3, 8'h90);  // CCF with C set
  endtask

  // --------------------------------------------------
  // Retirement monitor
  // --------------------------------------------------
  always @(negedge clk)
  begin
    expectT e;
    if (reset_n === 1'b1)
    begin
      if (retire !== 1'b0 && retire !== 1'b1)
        failRun("The retire output is unknown after reset");
      else if (retire)
      begin
        if (expQ.size() == 0)
          failRun("Retirement seen with no instruction in flight");
        else
        begin
          e = expQ.pop_front();
          checkValue("retire edge", edgeCount, e.dueEdge);
          checkValue("regWrite", 32'(regWrite), 32'(e.regWrite));
          if (e.regWrite)
          begin
            checkValue("wbReg", 32'(wbReg), 32'(e.wbReg));
            checkValue("wbData", 32'(wbData), 32'(e.wbData));
          end
          checkValue("flags", 32'(flags), 32'(e.flags));
        end
      end
      else if (expQ.size() != 0 && expQ[0].dueEdge <= edgeCount)
        failRun("An instruction did not retire at its expected edge");
    end
  end

  // Budget grows with the number of issued instructions
  initial
  begin
    wait (tableBuilt === 1'b1);
    #(CLK_PERIOD * (RESET_CYCLES + CYCLES_PER_INST * (stimTable.size() + NUM_RANDOM)));
    failRun("Timeout: the run did not finish within its cycle budget");
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin
    expectT      e;
    logic        legal;
    logic [31:0] due;
    logic [7:0]  opc;
    logic [7:0]  imm;

    reset_n    = 1'b0;
    instValid  = 1'b0;
    opcode     = 8'h00;
    operand    = 8'h00;
    edgeCount  = 0;
    tableBuilt = 1'b0;
    rngState   = 32'h1e20;
    resetModel();
    buildTable();
    tableBuilt = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset_n = 1'b1;

    foreach (stimTable[i])
    begin
      repeat (stimTable[i].gap) idleCycle();
      issueInst(stimTable[i].opc, stimTable[i].imm, due);
      modelStep(stimTable[i].opc, stimTable[i].imm, legal, e);  // Keep model in step
      if (stimTable[i].retires)
      begin
        e.dueEdge  = due;
        e.regWrite = stimTable[i].regWrite;
        e.wbReg    = stimTable[i].wbReg;
        e.wbData   = stimTable[i].wbData;
        e.flags    = stimTable[i].flags;
        expQ.push_back(e);
      end
    end

    // Random legal instructions mostly back to back
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      makeRandomInst(opc, imm);
      if (rngState[31:30] == 2'b00)
        idleCycle();
      issueInst(opc, imm, due);
      modelStep(opc, imm, legal, e);
      if (legal)
      begin
        e.dueEdge = due;
        expQ.push_back(e);
      end
    end

    idleCycle();
    while (expQ.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== byteCore.f ====
cpuPkg.sv
decodedOpIf.sv
writebackIf.sv
instDecode.sv
aluExecute.sv
regWriteback.sv
byteCore.sv
byteCore_assertions.sv
byteCore_tb.sv

// ==== Bender.yml ====
package:
  name: byte_core

sources:
  # Design, in compile order
  - cpuPkg.sv
  - decodedOpIf.sv
  - writebackIf.sv
  - instDecode.sv
  - aluExecute.sv
  - regWriteback.sv
  - byteCore.sv

  # Testbench and bound assertions
  - target: test
    files:
      - byteCore_assertions.sv
      - byteCore_tb.sv
